/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // alu_andn computes b & ~a, the CSRRC clear with a = rs1 and b = old csr
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_andn
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } br_op_e;

  typedef enum logic [2:0] {
    npc_seq, npc_jal, npc_jalr, npc_branch, npc_trap, npc_mret
  } npc_sel_e;

  typedef enum logic [1:0] {
    wb_alu, wb_pc4, wb_load, wb_csr
  } wb_sel_e;

  // second alu operand; op2_rs1_csr feeds the old csr value for set/clear
  typedef enum logic [1:0] {
    op2_rs2, op2_imm, op2_rs1_csr
  } op2_sel_e;

  // machine csr addresses
  localparam logic [11:0] csr_mtvec  = 12'h305;
  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  // environment call from machine mode
  localparam logic [31:0] cause_ecall = 32'd11;

endpackage

`default_nettype wire

/* hdl/rv_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
  input  wire logic [31:0]     inst,
  input  wire logic            inst_valid,
  output rv_pkg::npc_sel_e     npc_sel,
  output logic [31:0]          imm,
  output rv_pkg::op2_sel_e     op2_sel,
  output logic                 op1_pc,
  output rv_pkg::alu_op_e      alu_op,
  output rv_pkg::br_op_e       br_op,
  output logic [1:0]           mem_size,
  output logic                 load_unsigned,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic [4:0]           rd,
  output logic                 reg_wen,
  output rv_pkg::wb_sel_e      wb_sel,
  output logic [11:0]          csr_addr,
  output logic                 csr_wen,
  output rv_pkg::alu_op_e      csr_op,
  output logic                 ecall,
  output logic                 mret,
  output logic                 ebreak,
  output logic                 dmem_ren,
  output logic                 dmem_wen
);

  rv_pkg::opcode_e opcode;
  rv_pkg::alu_op_e arith_op;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [7:0]      f3;

  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // one-hot funct3, f3[n] is high when funct3 == n
  assign f3 = 8'b0000_0001 << funct3;

  wire f7_zero = funct7 == 7'b0000000;
  wire f7_alt  = funct7 == 7'b0100000;

  wire is_lui    = opcode == rv_pkg::opc_lui;
  wire is_auipc  = opcode == rv_pkg::opc_auipc;
  wire is_jal    = opcode == rv_pkg::opc_jal;
  wire is_jalr   = opcode == rv_pkg::opc_jalr & f3[0];
  wire is_branch = opcode == rv_pkg::opc_branch & ~(f3[2] | f3[3]);
  wire is_load   = opcode == rv_pkg::opc_load & (f3[0] | f3[1] | f3[2] | f3[4] | f3[5]);
  wire is_store  = opcode == rv_pkg::opc_store & (f3[0] | f3[1] | f3[2]);

  // immediate shifts need a clean funct7, the rest carry imm[11:5] there
  wire is_op_imm = opcode == rv_pkg::opc_op_imm &
                   (~(f3[1] | f3[5]) | (f3[1] & f7_zero) | (f3[5] & (f7_zero | f7_alt)));
  wire is_op     = opcode == rv_pkg::opc_op & (f7_zero | (f7_alt & (f3[0] | f3[5])));

  // register forms only, CSRRWI and friends are not decoded
  wire is_csr    = opcode == rv_pkg::opc_system & (f3[1] | f3[2] | f3[3]);

  wire is_ecall  = inst == 32'b0000000_00000_00000_000_00000_1110011;
  wire is_ebreak = inst == 32'b0000000_00001_00000_000_00000_1110011;
  wire is_mret   = inst == 32'b0011000_00010_00000_000_00000_1110011;

  // immediate by format, I is the fallback
  always_comb begin
    case (opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc:
        imm = {inst[31:12], 12'h000};
      rv_pkg::opc_jal:
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      rv_pkg::opc_branch:
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      rv_pkg::opc_store:
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:
        imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (is_op & funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  arith_op = rv_pkg::alu_sll;
      3'b010:  arith_op = rv_pkg::alu_slt;
      3'b011:  arith_op = rv_pkg::alu_sltu;
      3'b100:  arith_op = rv_pkg::alu_xor;
      3'b101:  arith_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
  end

  // everything else uses the adder: addresses, lui, auipc, jalr
  assign alu_op = (is_op | is_op_imm) ? arith_op : rv_pkg::alu_add;

  always_comb begin
    case (funct3)
      3'b110:  br_op = rv_pkg::br_ltu;
      3'b111:  br_op = rv_pkg::br_geu;
      3'b000:  br_op = rv_pkg::br_eq;
      3'b001:  br_op = rv_pkg::br_ne;
      3'b100:  br_op = rv_pkg::br_lt;
      3'b101:  br_op = rv_pkg::br_ge;
      default: br_op = rv_pkg::br_none;
    endcase
    if (!is_branch) begin
      br_op = rv_pkg::br_none;
    end
  end

  always_comb begin
    if (is_jal) begin
      npc_sel = rv_pkg::npc_jal;
    end else if (is_jalr) begin
      npc_sel = rv_pkg::npc_jalr;
    end else if (is_branch) begin
      npc_sel = rv_pkg::npc_branch;
    end else if (is_ecall) begin
      npc_sel = rv_pkg::npc_trap;
    end else if (is_mret) begin
      npc_sel = rv_pkg::npc_mret;
    end else begin
      npc_sel = rv_pkg::npc_seq;
    end
  end

  always_comb begin
    if (is_lui | is_auipc | is_jalr | is_load | is_store | is_op_imm) begin
      op2_sel = rv_pkg::op2_imm;
    end else if (is_csr & funct3[1]) begin
      op2_sel = rv_pkg::op2_rs1_csr;
    end else begin
      op2_sel = rv_pkg::op2_rs2;
    end
  end

  always_comb begin
    if (is_jal | is_jalr) begin
      wb_sel = rv_pkg::wb_pc4;
    end else if (is_load) begin
      wb_sel = rv_pkg::wb_load;
    end else if (is_csr) begin
      wb_sel = rv_pkg::wb_csr;
    end else begin
      wb_sel = rv_pkg::wb_alu;
    end
  end

  // csrrw passes rs1 through as rs1 + x0
  assign csr_op = f3[2] ? rv_pkg::alu_or : (f3[3] ? rv_pkg::alu_andn : rv_pkg::alu_add);
  assign csr_addr = inst[31:20];

  assign op1_pc        = is_auipc;
  assign mem_size      = funct3[1:0];
  assign load_unsigned = funct3[2];

  // lui reads x0 so the adder yields the immediate
  assign rs1 = is_lui ? 5'd0 : inst[19:15];
  assign rs2 = (is_csr & f3[1]) ? 5'd0 : inst[24:20];
  assign rd  = inst[11:7];

  assign reg_wen  = (is_lui | is_auipc | is_jal | is_jalr | is_load | is_op_imm | is_op |
                     is_csr) & inst_valid;
  assign csr_wen  = is_csr & inst_valid;
  assign ecall    = is_ecall & inst_valid;
  assign mret     = is_mret & inst_valid;
  assign ebreak   = is_ebreak & inst_valid;
  assign dmem_ren = is_load & inst_valid;
  assign dmem_wen = is_store & inst_valid;

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire logic [31:0]      a,
  input  wire logic [31:0]      b,
  input  wire rv_pkg::alu_op_e  alu_op,
  input  wire rv_pkg::br_op_e   br_op,
  output logic [31:0]           result,
  output logic                  taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'd0, lt_s};
      rv_pkg::alu_sltu: result = {31'd0, lt_u};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      // clears the bits of b that are set in a
      rv_pkg::alu_andn: result = b & ~a;
      default:          result = a + b;
    endcase
  end

  // compare runs beside the adder, result is not used by branches
  always_comb begin
    case (br_op)
      rv_pkg::br_eq:  taken = a == b;
      rv_pkg::br_ne:  taken = a != b;
      rv_pkg::br_lt:  taken = lt_s;
      rv_pkg::br_ge:  taken = ~lt_s;
      rv_pkg::br_ltu: taken = lt_u;
      rv_pkg::br_geu: taken = ~lt_u;
      default:        taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic [4:0]  rs1,
  input  wire logic [4:0]  rs2,
  input  wire logic        wen,
  input  wire logic [4:0]  rd,
  input  wire logic [31:0] wdata,
  output logic [31:0]      rdata1,
  output logic [31:0]      rdata2
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/rv_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic [11:0] addr,
  input  wire logic        wen,
  input  wire logic [31:0] wdata,
  input  wire logic        ecall,
  input  wire logic        mret,
  input  wire logic [31:0] pc,
  output logic [31:0]      rdata,
  output logic [31:0]      mtvec,
  output logic [31:0]      mepc
);

  logic [31:0] mcause;
  logic        sw_write;

  // trap entry and return own the cycle, no software write alongside
  assign sw_write = wen & ~ecall & ~mret;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec  <= reset_pc;
      mepc   <= '0;
      mcause <= '0;
    end else if (ecall) begin
      mepc   <= pc;
      mcause <= rv_pkg::cause_ecall;
    end else if (sw_write) begin
      case (addr)
        rv_pkg::csr_mtvec:  mtvec  <= wdata;
        rv_pkg::csr_mepc:   mepc   <= wdata;
        rv_pkg::csr_mcause: mcause <= wdata;
        default: ;
      endcase
    end
  end

  // unknown addresses read as zero
  always_comb begin
    case (addr)
      rv_pkg::csr_mtvec:  rdata = mtvec;
      rv_pkg::csr_mepc:   rdata = mepc;
      rv_pkg::csr_mcause: rdata = mcause;
      default:            rdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic [31:0] inst,
  input  wire logic        inst_valid,
  input  wire logic [31:0] dmem_rdata,
  output logic [31:0]      pc,
  output logic [31:0]      dmem_addr,
  output logic [31:0]      dmem_wdata,
  output logic [3:0]       dmem_wstrb,
  output logic             dmem_ren,
  output logic             dmem_wen,
  output logic             wb_en,
  output logic [4:0]       wb_rd,
  output logic [31:0]      wb_data,
  output logic             halt
);

  rv_pkg::npc_sel_e npc_sel;
  rv_pkg::op2_sel_e op2_sel;
  rv_pkg::alu_op_e  alu_op;
  rv_pkg::alu_op_e  csr_op;
  rv_pkg::alu_op_e  alu_op_mux;
  rv_pkg::br_op_e   br_op;
  rv_pkg::wb_sel_e  wb_sel;
  logic        valid;
  logic [31:0] imm;
  logic        op1_pc;
  logic [1:0]  mem_size;
  logic        load_unsigned;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        reg_wen;
  logic [11:0] csr_addr;
  logic        csr_wen;
  logic        ecall;
  logic        mret;
  logic        ebreak;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        taken;
  logic [31:0] pc4;
  logic [31:0] pc_imm;
  logic [31:0] npc;
  logic [31:0] rd_word;
  logic [31:0] load_data;
  logic [3:0]  strb_base;

  // a halted core accepts nothing until reset
  assign valid = inst_valid & ~halt;

  rv_idu u_idu (
    .inst(inst), .inst_valid(valid), .npc_sel(npc_sel), .imm(imm), .op2_sel(op2_sel),
    .op1_pc(op1_pc), .alu_op(alu_op), .br_op(br_op), .mem_size(mem_size),
    .load_unsigned(load_unsigned), .rs1(rs1), .rs2(rs2), .rd(wb_rd), .reg_wen(reg_wen),
    .wb_sel(wb_sel), .csr_addr(csr_addr), .csr_wen(csr_wen), .csr_op(csr_op),
    .ecall(ecall), .mret(mret), .ebreak(ebreak), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen)
  );

  // writes to x0 never reach the retire port
  assign wb_en = reg_wen & (wb_rd != 5'd0);

  rv_regfile u_regfile (
    .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .wen(wb_en), .rd(wb_rd),
    .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
  );

  assign alu_a = op1_pc ? pc : rdata1;
  always_comb begin
    case (op2_sel)
      rv_pkg::op2_imm:     alu_b = imm;
      rv_pkg::op2_rs1_csr: alu_b = csr_rdata;
      default:             alu_b = rdata2;
    endcase
  end
  assign alu_op_mux = (wb_sel == rv_pkg::wb_csr) ? csr_op : alu_op;

  rv_alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op_mux), .br_op(br_op), .result(alu_result),
    .taken(taken)
  );

  rv_csr #(.reset_pc(reset_pc)) u_csr (
    .clk(clk), .arst_n(arst_n), .addr(csr_addr), .wen(csr_wen), .wdata(alu_result),
    .ecall(ecall), .mret(mret), .pc(pc), .rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
  );

  // data port, lanes follow the low address bits
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rdata2 << {dmem_addr[1:0], 3'b000};
  always_comb begin
    case (mem_size)
      2'b00:   strb_base = 4'b0001;
      2'b01:   strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end
  assign dmem_wstrb = dmem_wen ? (strb_base << dmem_addr[1:0]) : 4'b0000;

  assign rd_word = dmem_rdata >> {dmem_addr[1:0], 3'b000};
  always_comb begin
    case (mem_size)
      2'b00:   load_data = {{24{~load_unsigned & rd_word[7]}}, rd_word[7:0]};
      2'b01:   load_data = {{16{~load_unsigned & rd_word[15]}}, rd_word[15:0]};
      default: load_data = rd_word;
    endcase
  end

  assign pc4    = pc + 32'd4;
  assign pc_imm = pc + imm;

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_pc4:  wb_data = pc4;
      rv_pkg::wb_load: wb_data = load_data;
      rv_pkg::wb_csr:  wb_data = csr_rdata;
      default:         wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (npc_sel)
      rv_pkg::npc_jal:    npc = pc_imm;
      rv_pkg::npc_jalr:   npc = {alu_result[31:1], 1'b0};
      rv_pkg::npc_branch: npc = taken ? pc_imm : pc4;
      rv_pkg::npc_trap:   npc = mtvec;
      rv_pkg::npc_mret:   npc = mepc;
      default:            npc = pc4;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else begin
      if (valid) begin
        pc <= npc;
      end
      // sticky until reset
      if (ebreak) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input wire logic        clk,
  input wire logic        arst_n,
  input wire logic [31:0] inst,
  input wire logic        inst_valid,
  input wire logic [31:0] pc,
  input wire logic [31:0] dmem_addr,
  input wire logic [31:0] dmem_wdata,
  input wire logic [3:0]  dmem_wstrb,
  input wire logic        dmem_ren,
  input wire logic        dmem_wen,
  input wire logic        wb_en,
  input wire logic [4:0]  wb_rd,
  input wire logic [31:0] wb_data,
  input wire logic        halt
);

  typedef struct packed {
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic [31:0] npc;
    logic        ren;
    logic        wr;
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] sdata;
    logic        csr_w;
    logic [11:0] csr_a;
    logic [31:0] csr_new;
    logic        ecall;
    logic        brk;
  } expect_t;

  int          errors;
  int          checks;
  logic [31:0] sh_regs [0:31];
  logic [31:0] sh_mem [0:255];
  logic [31:0] sh_pc;
  logic [31:0] sh_mtvec;
  logic [31:0] sh_mepc;
  logic [31:0] sh_mcause;
  logic        sh_halt;
  expect_t     exp_q;

  // same fill as the memory model in tb_top
  initial begin
    errors = 0;
    checks = 0;
    for (int i = 0; i < 256; i++) begin
      sh_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 + i[7:0]};
    end
  end

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic logic [31:0] csr_value(input logic [11:0] a);
    if (a == rv_pkg::csr_mtvec) return sh_mtvec;
    if (a == rv_pkg::csr_mepc) return sh_mepc;
    if (a == rv_pkg::csr_mcause) return sh_mcause;
    return 32'd0;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'd0, $signed(x) < $signed(y)};
      3'd3: return {31'd0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  // expected effects of one instruction on the shadow state
  function automatic expect_t predict(input logic [31:0] ins);
    expect_t     e;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] word;
    logic        cond;
    op = ins[6:0];
    f3 = ins[14:12];
    a = sh_regs[ins[19:15]];
    b = sh_regs[ins[24:20]];
    i_imm = {{20{ins[31]}}, ins[31:20]};
    s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e = '0;
    e.rd = ins[11:7];
    e.npc = sh_pc + 32'd4;
    case (op)
      rv_pkg::opc_lui: begin
        e.wen = 1'b1;
        e.wdata = {ins[31:12], 12'h000};
      end
      rv_pkg::opc_auipc: begin
        e.wen = 1'b1;
        e.wdata = sh_pc + {ins[31:12], 12'h000};
      end
      rv_pkg::opc_jal: begin
        e.wen = 1'b1;
        e.wdata = sh_pc + 32'd4;
        e.npc = sh_pc + j_imm;
      end
      rv_pkg::opc_jalr: begin
        e.wen = 1'b1;
        e.wdata = sh_pc + 32'd4;
        e.npc = (a + i_imm) & ~32'd1;
      end
      rv_pkg::opc_branch: begin
        case (f3)
          3'd0: cond = a == b;
          3'd1: cond = a != b;
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) e.npc = sh_pc + b_imm;
      end
      rv_pkg::opc_load: begin
        e.wen = 1'b1;
        e.ren = 1'b1;
        e.addr = a + i_imm;
        word = sh_mem[e.addr[9:2]] >> {e.addr[1:0], 3'b000};
        case (f3)
          3'd0: e.wdata = {{24{word[7]}}, word[7:0]};
          3'd1: e.wdata = {{16{word[15]}}, word[15:0]};
          3'd4: e.wdata = {24'd0, word[7:0]};
          3'd5: e.wdata = {16'd0, word[15:0]};
          default: e.wdata = word;
        endcase
      end
      rv_pkg::opc_store: begin
        e.wr = 1'b1;
        e.addr = a + s_imm;
        e.sdata = b << {e.addr[1:0], 3'b000};
        case (f3)
          3'd0: e.wstrb = 4'b0001 << e.addr[1:0];
          3'd1: e.wstrb = 4'b0011 << e.addr[1:0];
          default: e.wstrb = 4'b1111;
        endcase
      end
      rv_pkg::opc_op_imm, rv_pkg::opc_op: begin
        e.wen = 1'b1;
        e.wdata = alu_ref(f3, ins[30] & (op == rv_pkg::opc_op || f3 == 3'd5), a,
                          (op == rv_pkg::opc_op) ? b : i_imm);
      end
      rv_pkg::opc_system: begin
        if (f3 == 3'd0) begin
          if (ins[31:20] == 12'h000) begin
            e.ecall = 1'b1;
            e.npc = sh_mtvec;
          end else if (ins[31:20] == 12'h001) begin
            e.brk = 1'b1;
          end else begin
            e.npc = sh_mepc;
          end
        end else begin
          // csr forms return the old value
          e.wen = 1'b1;
          e.csr_w = 1'b1;
          e.csr_a = ins[31:20];
          e.wdata = csr_value(e.csr_a);
          case (f3)
            3'd1: e.csr_new = a;
            3'd2: e.csr_new = e.wdata | a;
            default: e.csr_new = e.wdata & ~a;
          endcase
        end
      end
      default: ;
    endcase
    return e;
  endfunction

  task automatic apply_shadow(input expect_t e);
    if (e.wen && e.rd != 5'd0) sh_regs[e.rd] = e.wdata;
    for (int j = 0; j < 4; j++) begin
      if (e.wr && e.wstrb[j]) sh_mem[e.addr[9:2]][8*j +: 8] = e.sdata[8*j +: 8];
    end
    if (e.csr_w) begin
      if (e.csr_a == rv_pkg::csr_mtvec) sh_mtvec = e.csr_new;
      if (e.csr_a == rv_pkg::csr_mepc) sh_mepc = e.csr_new;
      if (e.csr_a == rv_pkg::csr_mcause) sh_mcause = e.csr_new;
    end
    if (e.ecall) begin
      sh_mepc = sh_pc;
      sh_mcause = rv_pkg::cause_ecall;
    end
    if (e.brk) sh_halt = 1'b1;
    sh_pc = e.npc;
  endtask

  // outputs are settled half a cycle after the inputs change
  always @(negedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) sh_regs[i] = 32'd0;
      sh_pc = reset_pc;
      sh_mtvec = reset_pc;
      sh_mepc = 32'd0;
      sh_mcause = 32'd0;
      sh_halt = 1'b0;
      compare_value("pc in reset", pc, reset_pc);
      compare_value("halt in reset", {31'd0, halt}, 32'd0);
      compare_value("strobes in reset", {29'd0, wb_en, dmem_ren, dmem_wen}, 32'd0);
    end else begin
      compare_value("pc", pc, sh_pc);
      compare_value("halt", {31'd0, halt}, {31'd0, sh_halt});
      if (inst_valid) begin
        if (sh_halt) begin
          exp_q = '0;
          exp_q.npc = sh_pc;
        end else begin
          exp_q = predict(inst);
        end
        compare_value("wb_en", {31'd0, wb_en}, {31'd0, exp_q.wen && exp_q.rd != 5'd0});
        if (wb_en) begin
          compare_value("wb_rd", {27'd0, wb_rd}, {27'd0, exp_q.rd});
          compare_value("wb_data", wb_data, exp_q.wdata);
        end
        compare_value("dmem_ren", {31'd0, dmem_ren}, {31'd0, exp_q.ren});
        compare_value("dmem_wen", {31'd0, dmem_wen}, {31'd0, exp_q.wr});
        if (exp_q.ren || exp_q.wr) compare_value("dmem_addr", dmem_addr, exp_q.addr);
        if (exp_q.wr) begin
          compare_value("dmem_wstrb", {28'd0, dmem_wstrb}, {28'd0, exp_q.wstrb});
          compare_value("dmem_wdata", dmem_wdata & byte_mask(exp_q.wstrb),
                        exp_q.sdata & byte_mask(exp_q.wstrb));
        end
        apply_shadow(exp_q);
      end
    end
  end

endmodule

`default_nettype wire

/* verif/rv_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
  input wire logic        clk,
  input wire logic        arst_n,
  input wire logic [31:0] inst,
  input wire logic        inst_valid,
  input wire logic        wb_en,
  input wire logic [4:0]  wb_rd,
  input wire logic        dmem_ren,
  input wire logic        dmem_wen,
  input wire logic        halt
);

  int fails = 0;

  // a valid instruction that names x0 as rd never reaches the retire port
  assert property (@(posedge clk) disable iff (!arst_n)
                   inst_valid && inst[11:7] == 5'd0 |-> !wb_en && wb_rd == 5'd0)
    else begin
      $error("retire port wrote x0");
      fails++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) !(dmem_ren && dmem_wen))
    else begin
      $error("load and store strobes high together");
      fails++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) halt |=> halt)
    else begin
      $error("halt fell without reset");
      fails++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) halt |-> !wb_en && !dmem_wen)
    else begin
      $error("write while halted");
      fails++;
    end

endmodule

bind rv_core rv_core_asserts u_asserts (
  .clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid), .wb_en(wb_en),
  .wb_rd(wb_rd), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .halt(halt)
);

`default_nettype wire

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  // seed, alu, control, memory, csr and halt sections
  localparam int prog_len = 62 + 40 + 20 + 20 + 13 + 6;
  localparam int cycle_limit = prog_len + 40;

  logic        clk;
  logic        arst_n;
  logic [31:0] inst;
  logic        inst_valid;
  logic [31:0] dmem_rdata;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        dmem_ren;
  logic        dmem_wen;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        halt;
  logic [31:0] mem [0:255];
  logic [31:0] lfsr_state;
  int          cycles;
  logic [2:0]  br_f3 [0:5];
  logic [2:0]  ld_f3 [0:4];

  tb_clkgen #(.period_ns(40)) u_clkgen (.clk(clk));

  rv_core #(.reset_pc(reset_pc)) u_dut (
    .clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid),
    .dmem_rdata(dmem_rdata), .pc(pc), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .wb_en(wb_en),
    .wb_rd(wb_rd), .wb_data(wb_data), .halt(halt)
  );

  tb_checker #(.reset_pc(reset_pc)) u_chk (
    .clk(clk), .arst_n(arst_n), .inst(inst), .inst_valid(inst_valid), .pc(pc),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .wb_en(wb_en), .wb_rd(wb_rd),
    .wb_data(wb_data), .halt(halt)
  );

  // data memory, combinational read and byte-lane write
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 + i[7:0]};
    end
  end
  assign dmem_rdata = mem[dmem_addr[9:2]];
  always @(posedge clk) begin
    for (int j = 0; j < 4; j++) begin
      if (dmem_wen && dmem_wstrb[j]) mem[dmem_addr[9:2]][8*j +: 8] <= dmem_wdata[8*j +: 8];
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    #5;
    inst = word;
    inst_valid = 1'b1;
  endtask

  task automatic random_alu(input logic [4:0] rd);
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rs2;
    logic [11:0] imm;
    kind = rand_bits(2);
    f3 = rand_bits(3);
    alt = rand_bits(1);
    rs2 = rand_bits(5);
    case (kind)
      2'd0: issue(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                        rs2, rand_bits(5), f3, rd));
      2'd1: begin
        if (f3 == 3'd1) imm = {7'h00, rs2};
        else if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, rs2};
        else imm = rand_bits(12);
        issue(enc_i(imm, rand_bits(5), f3, rd, rv_pkg::opc_op_imm));
      end
      2'd2: issue({rand_bits(20), rd, rv_pkg::opc_lui});
      default: issue({rand_bits(20), rd, rv_pkg::opc_auipc});
    endcase
  endtask

  task automatic memory_pair(input int k);
    logic [7:0]  word;
    logic [1:0]  lane;
    logic [2:0]  lf3;
    word = rand_bits(8);
    case (k % 3)
      0: lane = rand_bits(2);
      1: lane = {rand_bits(1), 1'b0};
      default: lane = 2'd0;
    endcase
    issue(enc_s({2'b00, word, lane}, rand_bits(5), 3'(k % 3)));
    lf3 = ld_f3[k % 5];
    // aligned lane for the load size
    if (lf3[1:0] == 2'd0) lane = rand_bits(2);
    else if (lf3[1:0] == 2'd1) lane = {rand_bits(1), 1'b0};
    else lane = 2'd0;
    issue(enc_i({2'b00, word, lane}, 5'd0, lf3, rand_bits(5), rv_pkg::opc_load));
  endtask

  initial begin
    arst_n = 1'b0;
    inst = 32'd0;
    inst_valid = 1'b0;
    lfsr_state = 32'hc6c5_565e;
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    repeat (2) @(posedge clk);
    #5;
    arst_n = 1'b1;
    for (int r = 1; r < 32; r++) begin
      issue({rand_bits(20), 5'(r), rv_pkg::opc_lui});
      issue(enc_i(rand_bits(12), 5'(r), 3'd0, 5'(r), rv_pkg::opc_op_imm));
    end
    for (int k = 0; k < 40; k++) begin
      random_alu((k % 8 == 3) ? 5'd0 : 5'(rand_bits(5)));
    end
    for (int k = 0; k < 4; k++) begin
      issue(enc_j(21'(signed'(12'(rand_bits(12)))), rand_bits(5)));
      issue(enc_i(rand_bits(12), rand_bits(5), 3'd0, rand_bits(5), rv_pkg::opc_jalr));
    end
    for (int k = 0; k < 12; k++) begin
      issue(enc_b(13'(signed'(12'(rand_bits(12)))), (k % 2) ? 5'd9 : 5'(rand_bits(5)),
                  (k % 2) ? 5'd9 : 5'(rand_bits(5)), br_f3[k / 2]));
    end
    for (int k = 0; k < 10; k++) begin
      memory_pair(k);
    end
    // x9 overlaps the reset mtvec in bit 31 so csrrs has to or the bits
    issue({20'h80000, 5'd9, rv_pkg::opc_lui});
    issue(enc_i(rv_pkg::csr_mtvec, 5'd9, 3'd2, 5'd5, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mtvec, 5'd7, 3'd1, 5'd6, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mcause, 5'd0, 3'd1, 5'd0, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mcause, 5'd9, 3'd2, 5'd8, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mcause, 5'd11, 3'd3, 5'd10, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mepc, 5'd13, 3'd1, 5'd12, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mepc, 5'd15, 3'd3, 5'd14, rv_pkg::opc_system));
    issue(32'h0000_0073);
    issue(enc_i(rv_pkg::csr_mepc, 5'd0, 3'd2, 5'd16, rv_pkg::opc_system));
    issue(enc_i(rv_pkg::csr_mcause, 5'd0, 3'd2, 5'd17, rv_pkg::opc_system));
    issue(32'h3020_0073);
    issue(enc_i(rv_pkg::csr_mtvec, 5'd0, 3'd2, 5'd18, rv_pkg::opc_system));
    // ebreak, then instructions that must have no effect
    issue(32'h0010_0073);
    for (int k = 0; k < 3; k++) begin
      issue(enc_r(7'h00, rand_bits(5), rand_bits(5), 3'd0, 5'd20 + 5'(k)));
    end
    issue(enc_s(12'h010, 5'd3, 3'd2));
    issue(enc_j(21'h00100, 5'd1));
    @(posedge clk);
    #5;
    inst_valid = 1'b0;
    repeat (3) @(posedge clk);
    $display("checks: %0d, errors: %0d, assertion failures: %0d", u_chk.checks,
             u_chk.errors, u_dut.u_asserts.fails);
    if (u_chk.errors == 0 && u_dut.u_asserts.fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_idu.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_csr.sv
hdl/rv_core.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/rv_core_asserts.sv
verif/tb_top.sv
